//--- common/cpuPkg.sv
package cpuPkg;

  // data word and byte address
  typedef logic [31:0] wordT;

  // architectural register index
  typedef logic [4:0] regIdT;

  // raw instruction word
  typedef logic [31:0] instT;

  // alu operations, compare ops give 1 or 0 in bit 0
  typedef enum logic [4:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB,
    aluEq,
    aluNe,
    aluLt,
    aluGe,
    aluLtu,
    aluGeu
  } aluOpE;

  // load/store access size
  typedef enum logic [1:0] {
    byteW,
    halfW,
    wordW
  } memWidthE;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opSystem = 7'b1110011;

  // addi x0, x0, 0
  localparam instT nopInst = 32'h00000013;

endpackage

//--- common/idExIf.sv
`timescale 1ns/1ps

interface idExIf;
  import cpuPkg::*;

  // one decoded instruction, operands already forwarded
  logic     valid;
  wordT     pc;
  regIdT    rd;
  logic     regWrite;
  aluOpE    aluOp;
  wordT     imm;
  wordT     rs1Data;
  wordT     rs2Data;
  logic     useImm;
  logic     usePcA;
  logic     isJal;
  logic     isJalr;
  logic     isBranch;
  logic     isLoad;
  logic     isStore;
  memWidthE memWidth;
  logic     loadUnsigned;
  logic     isEbreak;
  logic     illegal;

  modport producer (
    output valid, pc, rd, regWrite, aluOp, imm, rs1Data, rs2Data, useImm, usePcA,
    output isJal, isJalr, isBranch, isLoad, isStore, memWidth, loadUnsigned,
    output isEbreak, illegal
  );

  modport consumer (
    input valid, pc, rd, regWrite, aluOp, imm, rs1Data, rs2Data, useImm, usePcA,
    input isJal, isJalr, isBranch, isLoad, isStore, memWidth, loadUnsigned,
    input isEbreak, illegal
  );

endinterface

//--- cpu.f
+incdir+verification
common/cpuPkg.sv
common/idExIf.sv
src/fetchUnit.sv
decode/decoder.sv
decode/registerFile.sv
decode/decodeStage.sv
execute/alu.sv
execute/dataMemory.sv
execute/executeStage.sv
src/cpuTop.sv
verification/clockGen.sv
verification/cpuTb.sv

//--- decode/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::instT  decInst,
  input  cpuPkg::wordT  decPc,
  input  logic          decValid,
  input  logic          redirect,
  input  logic          haltReq,
  input  logic          fwdValid,
  input  cpuPkg::regIdT fwdRd,
  input  cpuPkg::wordT  fwdData,
  idExIf.producer       idEx
);
  import cpuPkg::*;

  regIdT    rs1;
  regIdT    rs2;
  regIdT    rd;
  wordT     imm;
  aluOpE    aluOp;
  memWidthE memWidth;
  logic     regWrite;
  logic     useImm;
  logic     usePcA;
  logic     isJal;
  logic     isJalr;
  logic     isBranch;
  logic     isLoad;
  logic     isStore;
  logic     loadUnsigned;
  logic     isEbreak;
  logic     illegal;
  wordT     rfDataA;
  wordT     rfDataB;
  wordT     rs1Data;
  wordT     rs2Data;

  decoder dec (
    .inst         (decInst),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .imm          (imm),
    .aluOp        (aluOp),
    .memWidth     (memWidth),
    .regWrite     (regWrite),
    .useImm       (useImm),
    .usePcA       (usePcA),
    .isJal        (isJal),
    .isJalr       (isJalr),
    .isBranch     (isBranch),
    .isLoad       (isLoad),
    .isStore      (isStore),
    .loadUnsigned (loadUnsigned),
    .isEbreak     (isEbreak),
    .illegal      (illegal)
  );

  // written from execute write-back
  registerFile regFile (
    .clk    (clk),
    .wen    (fwdValid),
    .waddr  (fwdRd),
    .wdata  (fwdData),
    .raddrA (rs1),
    .raddrB (rs2),
    .rdataA (rfDataA),
    .rdataB (rfDataB)
  );

  // execute result bypasses the write that lands this edge
  assign rs1Data = (fwdValid && fwdRd == rs1) ? fwdData : rfDataA;
  assign rs2Data = (fwdValid && fwdRd == rs2) ? fwdData : rfDataB;

  // valid dropped on redirect or halt
  always_ff @(posedge clk) begin
    if (!rstN) begin
      idEx.valid <= 1'b0;
    end else begin
      idEx.valid <= decValid && !redirect && !haltReq;
    end
  end

  // payload, meaningful only with valid
  always_ff @(posedge clk) begin
    idEx.pc           <= decPc;
    idEx.rd           <= rd;
    idEx.regWrite     <= regWrite;
    idEx.aluOp        <= aluOp;
    idEx.imm          <= imm;
    idEx.rs1Data      <= rs1Data;
    idEx.rs2Data      <= rs2Data;
    idEx.useImm       <= useImm;
    idEx.usePcA       <= usePcA;
    idEx.isJal        <= isJal;
    idEx.isJalr       <= isJalr;
    idEx.isBranch     <= isBranch;
    idEx.isLoad       <= isLoad;
    idEx.isStore      <= isStore;
    idEx.memWidth     <= memWidth;
    idEx.loadUnsigned <= loadUnsigned;
    idEx.isEbreak     <= isEbreak;
    idEx.illegal      <= illegal;
  end

endmodule

//--- decode/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  cpuPkg::instT     inst,
  output cpuPkg::regIdT    rs1,
  output cpuPkg::regIdT    rs2,
  output cpuPkg::regIdT    rd,
  output cpuPkg::wordT     imm,
  output cpuPkg::aluOpE    aluOp,
  output cpuPkg::memWidthE memWidth,
  output logic             regWrite,
  output logic             useImm,
  output logic             usePcA,
  output logic             isJal,
  output logic             isJalr,
  output logic             isBranch,
  output logic             isLoad,
  output logic             isStore,
  output logic             loadUnsigned,
  output logic             isEbreak,
  output logic             illegal
);
  import cpuPkg::*;

  localparam instT ebreakInst = 32'h00100073;

  logic [2:0] funct3;
  aluOpE      arithOp;
  wordT       immI;
  wordT       immS;
  wordT       immB;
  wordT       immU;
  wordT       immJ;

  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];

  // immediate formats
  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // width and sign straight from funct3 for loads and stores
  assign memWidth     = (funct3[1:0] == 2'b00) ? byteW :
                        (funct3[1:0] == 2'b01) ? halfW : wordW;
  assign loadUnsigned = funct3[2];

  // shared funct3 map for op-imm and op
  always_comb begin
    case (funct3)
      3'b000:  arithOp = (inst[5] && inst[30]) ? aluSub : aluAdd;
      3'b001:  arithOp = aluSll;
      3'b010:  arithOp = aluSlt;
      3'b011:  arithOp = aluSltu;
      3'b100:  arithOp = aluXor;
      3'b101:  arithOp = inst[30] ? aluSra : aluSrl;
      3'b110:  arithOp = aluOr;
      default: arithOp = aluAnd;
    endcase
  end

  always_comb begin
    // defaults give a no-op with no write
    imm      = immI;
    aluOp    = aluAdd;
    regWrite = 1'b0;
    useImm   = 1'b0;
    usePcA   = 1'b0;
    isJal    = 1'b0;
    isJalr   = 1'b0;
    isBranch = 1'b0;
    isLoad   = 1'b0;
    isStore  = 1'b0;
    isEbreak = 1'b0;
    illegal  = 1'b0;
    case (inst[6:0])
      opLui: begin
        imm      = immU;
        aluOp    = aluPassB;
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      opAuipc: begin
        imm      = immU;
        usePcA   = 1'b1;
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      opJal: begin
        // pc + imm is the target
        imm      = immJ;
        usePcA   = 1'b1;
        useImm   = 1'b1;
        isJal    = 1'b1;
        regWrite = 1'b1;
      end
      opJalr: begin
        useImm   = 1'b1;
        isJalr   = 1'b1;
        regWrite = 1'b1;
      end
      opBranch: begin
        // compare rs1 with rs2, target added separately in execute
        imm      = immB;
        isBranch = 1'b1;
        case (funct3)
          3'b000:  aluOp = aluEq;
          3'b001:  aluOp = aluNe;
          3'b100:  aluOp = aluLt;
          3'b101:  aluOp = aluGe;
          3'b110:  aluOp = aluLtu;
          3'b111:  aluOp = aluGeu;
          default: begin
            isBranch = 1'b0;
            illegal  = 1'b1;
          end
        endcase
      end
      opLoad: begin
        useImm   = 1'b1;
        isLoad   = 1'b1;
        regWrite = 1'b1;
      end
      opStore: begin
        imm     = immS;
        useImm  = 1'b1;
        isStore = 1'b1;
      end
      opImm: begin
        aluOp    = arithOp;
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      opReg: begin
        aluOp    = arithOp;
        regWrite = 1'b1;
      end
      opSystem: begin
        // only ebreak, ecall and csr ops are not kept
        isEbreak = (inst == ebreakInst);
        illegal  = (inst != ebreakInst);
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

//--- decode/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic          clk,
  input  logic          wen,
  input  cpuPkg::regIdT waddr,
  input  cpuPkg::wordT  wdata,
  input  cpuPkg::regIdT raddrA,
  input  cpuPkg::regIdT raddrB,
  output cpuPkg::wordT  rdataA,
  output cpuPkg::wordT  rdataB
);
  import cpuPkg::*;

  wordT regs [32];

  // single write port, x0 never written
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // async reads, x0 reads zero
  assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

//--- execute/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpuPkg::wordT  a,
  input  cpuPkg::wordT  b,
  input  cpuPkg::aluOpE op,
  output cpuPkg::wordT  result
);
  import cpuPkg::*;

  logic [4:0] shamt;
  logic       ltSigned;
  logic       ltUnsigned;

  assign shamt      = b[4:0];
  assign ltSigned   = $signed(a) < $signed(b);
  assign ltUnsigned = a < b;

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluSll:   result = a << shamt;
      aluSlt:   result = {31'b0, ltSigned};
      aluSltu:  result = {31'b0, ltUnsigned};
      aluXor:   result = a ^ b;
      aluSrl:   result = a >> shamt;
      aluSra:   result = $signed(a) >>> shamt;
      aluOr:    result = a | b;
      aluAnd:   result = a & b;
      // lui immediate passes through
      aluPassB: result = b;
      // branch compares
      aluEq:    result = {31'b0, a == b};
      aluNe:    result = {31'b0, a != b};
      aluLt:    result = {31'b0, ltSigned};
      aluGe:    result = {31'b0, !ltSigned};
      aluLtu:   result = {31'b0, ltUnsigned};
      aluGeu:   result = {31'b0, !ltUnsigned};
      default:  result = '0;
    endcase
  end

endmodule

//--- execute/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
  parameter int dataMemWords = 256
) (
  input  logic             clk,
  input  cpuPkg::wordT     addr,
  input  cpuPkg::wordT     wdata,
  input  logic             write,
  input  logic             read,
  input  cpuPkg::memWidthE width,
  input  logic             loadUnsigned,
  output cpuPkg::wordT     rdata
);
  import cpuPkg::*;

  localparam int idxBits = $clog2(dataMemWords);

  wordT               mem [dataMemWords];
  logic [idxBits-1:0] wordIdx;
  logic [3:0]         byteEn;
  wordT               laneData;
  wordT               shifted;
  wordT               extended;

  // word index above the byte offset
  assign wordIdx = addr[idxBits+1:2];

  // lane enables and replicated store data
  always_comb begin
    case (width)
      byteW: begin
        byteEn   = 4'b0001 << addr[1:0];
        laneData = {4{wdata[7:0]}};
      end
      halfW: begin
        byteEn   = addr[1] ? 4'b1100 : 4'b0011;
        laneData = {2{wdata[15:0]}};
      end
      default: begin
        byteEn   = 4'b1111;
        laneData = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (write && byteEn[i]) begin
        mem[wordIdx][i*8 +: 8] <= laneData[i*8 +: 8];
      end
    end
  end

  // addressed byte or half moved to bit 0
  assign shifted = mem[wordIdx] >> {addr[1:0], 3'b000};

  always_comb begin
    case (width)
      byteW:   extended = {{24{!loadUnsigned && shifted[7]}}, shifted[7:0]};
      halfW:   extended = {{16{!loadUnsigned && shifted[15]}}, shifted[15:0]};
      default: extended = shifted;
    endcase
  end

  assign rdata = read ? extended : '0;

endmodule

//--- execute/executeStage.sv
`timescale 1ns/1ps

module executeStage #(
  parameter int dataMemWords = 256
) (
  input  logic          clk,
  idExIf.consumer       idEx,
  output logic          redirect,
  output cpuPkg::wordT  redirectPc,
  output logic          haltReq,
  output logic          fwdValid,
  output cpuPkg::regIdT fwdRd,
  output cpuPkg::wordT  fwdData,
  output logic          retireValid,
  output cpuPkg::wordT  retirePc,
  output cpuPkg::regIdT retireRd,
  output logic          retireWrite,
  output cpuPkg::wordT  retireData,
  output logic          retireIllegal
);
  import cpuPkg::*;

  wordT opA;
  wordT opB;
  wordT aluResult;
  wordT loadData;
  wordT wbData;
  logic isJump;

  // operand select
  assign opA = idEx.usePcA ? idEx.pc : idEx.rs1Data;
  assign opB = idEx.useImm ? idEx.imm : idEx.rs2Data;

  alu aluUnit (
    .a      (opA),
    .b      (opB),
    .op     (idEx.aluOp),
    .result (aluResult)
  );

  // address from alu, store data is forwarded rs2
  dataMemory #(
    .dataMemWords (dataMemWords)
  ) dmem (
    .clk          (clk),
    .addr         (aluResult),
    .wdata        (idEx.rs2Data),
    .write        (idEx.valid && idEx.isStore),
    .read         (idEx.valid && idEx.isLoad),
    .width        (idEx.memWidth),
    .loadUnsigned (idEx.loadUnsigned),
    .rdata        (loadData)
  );

  // branch taken when compare gives 1
  assign isJump     = idEx.isJal || idEx.isJalr;
  assign redirect   = idEx.valid && (isJump || (idEx.isBranch && aluResult[0]));
  assign redirectPc = isJump ? {aluResult[31:1], 1'b0} : idEx.pc + idEx.imm;
  assign haltReq    = idEx.valid && idEx.isEbreak;

  // write-back select, link value for jumps
  assign wbData = isJump      ? idEx.pc + 32'd4 :
                  idEx.isLoad ? loadData : aluResult;

  // x0 writes are dropped here
  assign fwdValid = idEx.valid && idEx.regWrite && idEx.rd != '0;
  assign fwdRd    = idEx.rd;
  assign fwdData  = wbData;

  // retire strobe, no back-pressure
  assign retireValid   = idEx.valid;
  assign retirePc      = idEx.pc;
  assign retireRd      = idEx.rd;
  assign retireWrite   = fwdValid;
  assign retireData    = wbData;
  assign retireIllegal = idEx.valid && idEx.illegal;

endmodule

//--- src/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
  parameter cpuPkg::wordT resetPc      = '0,
  parameter int           dataMemWords = 256
) (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::instT  instData,
  output cpuPkg::wordT  instAddr,
  output logic          retireValid,
  output cpuPkg::wordT  retirePc,
  output cpuPkg::regIdT retireRd,
  output logic          retireWrite,
  output cpuPkg::wordT  retireData,
  output logic          retireIllegal,
  output logic          halted
);
  import cpuPkg::*;

  // fetch to decode
  instT  decInst;
  wordT  decPc;
  logic  decValid;

  // execute back to fetch and decode
  logic  redirect;
  wordT  redirectPc;
  logic  haltReq;
  logic  fwdValid;
  regIdT fwdRd;
  wordT  fwdData;

  // decode-to-execute register
  idExIf idExBus ();

  fetchUnit #(
    .resetPc (resetPc)
  ) fetch (
    .clk        (clk),
    .rstN       (rstN),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .haltReq    (haltReq),
    .instData   (instData),
    .instAddr   (instAddr),
    .decInst    (decInst),
    .decPc      (decPc),
    .decValid   (decValid),
    .halted     (halted)
  );

  decodeStage decode (
    .clk      (clk),
    .rstN     (rstN),
    .decInst  (decInst),
    .decPc    (decPc),
    .decValid (decValid),
    .redirect (redirect),
    .haltReq  (haltReq),
    .fwdValid (fwdValid),
    .fwdRd    (fwdRd),
    .fwdData  (fwdData),
    .idEx     (idExBus.producer)
  );

  executeStage #(
    .dataMemWords (dataMemWords)
  ) execute (
    .clk           (clk),
    .idEx          (idExBus.consumer),
    .redirect      (redirect),
    .redirectPc    (redirectPc),
    .haltReq       (haltReq),
    .fwdValid      (fwdValid),
    .fwdRd         (fwdRd),
    .fwdData       (fwdData),
    .retireValid   (retireValid),
    .retirePc      (retirePc),
    .retireRd      (retireRd),
    .retireWrite   (retireWrite),
    .retireData    (retireData),
    .retireIllegal (retireIllegal)
  );

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
  parameter cpuPkg::wordT resetPc = '0
) (
  input  logic          clk,
  input  logic          rstN,
  input  logic          redirect,
  input  cpuPkg::wordT  redirectPc,
  input  logic          haltReq,
  input  cpuPkg::instT  instData,
  output cpuPkg::wordT  instAddr,
  output cpuPkg::instT  decInst,
  output cpuPkg::wordT  decPc,
  output logic          decValid,
  output logic          halted
);
  import cpuPkg::*;

  wordT pc;
  logic stopFetch;
  logic squash;

  // halt takes effect in the same cycle ebreak executes
  assign stopFetch = halted || haltReq;
  assign squash    = redirect || stopFetch;

  // fetch port is combinational, pc goes straight out
  assign instAddr = pc;

  // pc and halt flag
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc     <= resetPc;
      halted <= 1'b0;
    end else begin
      if (haltReq) begin
        halted <= 1'b1;
      end
      // pc freezes once halted
      if (!stopFetch) begin
        pc <= redirect ? redirectPc : pc + 32'd4;
      end
    end
  end

  // fetch-to-decode valid
  always_ff @(posedge clk) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else begin
      decValid <= !squash;
    end
  end

  // fetch-to-decode payload, nop on squash
  always_ff @(posedge clk) begin
    decInst <= squash ? nopInst : instData;
    decPc   <= pc;
  end

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int periodNs    = 100,
  parameter int resetCycles = 3
) (
  output logic clk,
  output logic rstN
);

  // free-running clock
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // reset low for a few edges, released just after a rising edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

//--- verification/rv32Model.svh
`ifndef RV32_MODEL_SVH
`define RV32_MODEL_SVH

// architectural state of the reference
wordT       mRegs [32];
logic [7:0] mMem [1024];
wordT       mPc;

// x0 pinned, other registers written by the program
task automatic resetModel(input wordT startPc);
  mRegs[0] = '0;
  mPc      = startPc;
endtask

// funct3 semantics shared by op-imm and op
function automatic wordT aluCalc(
  input logic [2:0] f3,
  input logic       alt,
  input wordT       a,
  input wordT       b
);
  wordT r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: r = (a < b) ? 32'd1 : 32'd0;
    3'd4: r = a ^ b;
    3'd5: begin
      // arithmetic shift kept apart from the unsigned path
      if (alt) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a >> b[4:0];
      end
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// branch condition by funct3
function automatic logic branchTaken(input logic [2:0] f3, input wordT a, input wordT b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

// little-endian load with extension
function automatic wordT loadValue(input wordT addr, input logic [2:0] f3);
  logic [9:0] i;
  logic [7:0] b0;
  logic [7:0] b1;
  i  = addr[9:0];
  b0 = mMem[i];
  b1 = mMem[i + 10'd1];
  case (f3)
    3'd0: return {{24{b0[7]}}, b0};
    3'd1: return {{16{b1[7]}}, b1, b0};
    3'd4: return {24'b0, b0};
    3'd5: return {16'b0, b1, b0};
    default: return {mMem[i + 10'd3], mMem[i + 10'd2], b1, b0};
  endcase
endfunction

task automatic storeValue(input wordT addr, input logic [2:0] f3, input wordT data);
  logic [9:0] i;
  i       = addr[9:0];
  mMem[i] = data[7:0];
  // half and word carry the upper lanes too
  if (f3 != 3'd0) begin
    mMem[i + 10'd1] = data[15:8];
  end
  if (f3 == 3'd2) begin
    mMem[i + 10'd2] = data[23:16];
    mMem[i + 10'd3] = data[31:24];
  end
endtask

// executes one instruction, returns what the retire port should show
task automatic stepModel(
  input  instT  inst,
  output wordT  ePc,
  output logic  eWrite,
  output regIdT eRd,
  output wordT  eData,
  output logic  eIllegal,
  output logic  eHalt
);
  logic [2:0] f3;
  wordT       a;
  wordT       b;
  wordT       immI;
  wordT       immS;
  wordT       immB;
  wordT       immU;
  wordT       immJ;
  wordT       nextPc;
  wordT       res;
  logic       wr;
  f3       = inst[14:12];
  a        = mRegs[inst[19:15]];
  b        = mRegs[inst[24:20]];
  immI     = {{20{inst[31]}}, inst[31:20]};
  immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  immB     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  immU     = {inst[31:12], 12'b0};
  immJ     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  nextPc   = mPc + 32'd4;
  res      = '0;
  wr       = 1'b0;
  eIllegal = 1'b0;
  eHalt    = 1'b0;
  case (inst[6:0])
    opLui: begin
      res = immU;
      wr  = 1'b1;
    end
    opAuipc: begin
      res = mPc + immU;
      wr  = 1'b1;
    end
    opJal: begin
      res    = mPc + 32'd4;
      wr     = 1'b1;
      nextPc = mPc + immJ;
    end
    opJalr: begin
      res    = mPc + 32'd4;
      wr     = 1'b1;
      nextPc = (a + immI) & ~32'd1;
    end
    opBranch: begin
      // funct3 2 and 3 are reserved
      if (f3 == 3'd2 || f3 == 3'd3) begin
        eIllegal = 1'b1;
      end else if (branchTaken(f3, a, b)) begin
        nextPc = mPc + immB;
      end
    end
    opLoad: begin
      res = loadValue(a + immI, f3);
      wr  = 1'b1;
    end
    opStore: storeValue(a + immS, f3, b);
    opImm: begin
      res = aluCalc(f3, f3 == 3'd5 && inst[30], a, immI);
      wr  = 1'b1;
    end
    opReg: begin
      res = aluCalc(f3, inst[30], a, b);
      wr  = 1'b1;
    end
    opSystem: begin
      eHalt    = (inst == 32'h00100073);
      eIllegal = !eHalt;
    end
    default: eIllegal = 1'b1;
  endcase
  // x0 keeps zero
  eWrite = wr && inst[11:7] != 5'd0;
  if (eWrite) begin
    mRegs[inst[11:7]] = res;
  end
  ePc   = mPc;
  eRd   = inst[11:7];
  eData = res;
  mPc   = nextPc;
endtask

`endif

//--- verification/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
  import cpuPkg::*;

  localparam int   progWords     = 1024;
  localparam int   regInitLen    = 62;
  localparam int   memInitLen    = 16;
  localparam int   bodyStart     = regInitLen + memInitLen;
  localparam int   bodyLen       = 300;
  localparam int   endIdx        = bodyStart + bodyLen;
  localparam int   memWindow     = 64;
  localparam int   resetTimeout  = 20;
  localparam int   retireTimeout = 10;
  localparam int   haltWindow    = 16;
  localparam int   maxRetires    = 1000;
  localparam instT ebreakInst    = 32'h00100073;
  localparam wordT startPc       = '0;

  logic   clk;
  logic   rstN;
  instT   instData;
  wordT   instAddr;
  logic   retireValid;
  wordT   retirePc;
  regIdT  retireRd;
  logic   retireWrite;
  wordT   retireData;
  logic   retireIllegal;
  logic   halted;

  instT   prog [progWords];
  bit     isTarget [progWords];
  integer seed = 32'h396485a1;
  int     mismatches = 0;
  int     otherErrors = 0;
  int     retired = 0;

  `include "rv32Model.svh"

  clockGen clocks (
    .clk  (clk),
    .rstN (rstN)
  );

  cpuTop #(
    .resetPc      (startPc),
    .dataMemWords (256)
  ) dut (
    .clk           (clk),
    .rstN          (rstN),
    .instData      (instData),
    .instAddr      (instAddr),
    .retireValid   (retireValid),
    .retirePc      (retirePc),
    .retireRd      (retireRd),
    .retireWrite   (retireWrite),
    .retireData    (retireData),
    .retireIllegal (retireIllegal),
    .halted        (halted)
  );

  // instruction ROM answers in the same cycle
  assign instData = prog[instAddr[11:2]];

  function automatic int randBelow(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // encoders for the instruction formats
  function automatic instT rType(
    input logic [6:0] f7,
    input regIdT      rs2,
    input regIdT      rs1,
    input logic [2:0] f3,
    input regIdT      rd
  );
    return {f7, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic instT iType(
    input logic [11:0] imm,
    input regIdT       rs1,
    input logic [2:0]  f3,
    input regIdT       rd,
    input logic [6:0]  op
  );
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instT sType(
    input logic [11:0] imm,
    input regIdT       rs2,
    input regIdT       rs1,
    input logic [2:0]  f3
  );
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
  endfunction

  function automatic instT bType(
    input logic [12:0] off,
    input regIdT       rs2,
    input regIdT       rs1,
    input logic [2:0]  f3
  );
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
  endfunction

  function automatic instT uType(input logic [19:0] imm, input regIdT rd, input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic instT jType(input logic [20:0] off, input regIdT rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
  endfunction

  // forward target that never passes the final ebreak
  function automatic int pickTarget(input int from);
    int tgt;
    tgt = from + 1 + randBelow(6);
    if (tgt > endIdx) begin
      tgt = endIdx;
    end
    isTarget[tgt] = 1'b1;
    return tgt;
  endfunction

  task automatic buildProgram();
    int          n;
    int          kind;
    int          tgt;
    int          off;
    logic [2:0]  f3;
    logic [11:0] imm;
    regIdT       rd;
    regIdT       rs1;
    regIdT       rs2;
    regIdT       rx;
    for (n = 0; n < progWords; n++) begin
      prog[n]     = nopInst;
      isTarget[n] = 1'b0;
    end
    // lui then addi on the same register so the addi needs forwarding
    for (n = 1; n < 32; n++) begin
      prog[2*n-2] = uType(20'($random(seed)), regIdT'(n), opLui);
      prog[2*n-1] = iType(12'($random(seed)), regIdT'(n), 3'd0, regIdT'(n), opImm);
    end
    // fill the data window before any load
    for (n = 0; n < memInitLen; n++) begin
      prog[regInitLen+n] = sType(12'(n * 4), regIdT'(n + 1), 5'd0, 3'd2);
    end
    n = bodyStart;
    while (n < endIdx) begin
      kind = randBelow(20);
      f3   = 3'(randBelow(8));
      rd   = regIdT'(randBelow(8));
      rs1  = regIdT'(randBelow(12));
      rs2  = regIdT'(randBelow(12));
      // jalr pair needs two slots and no branch landing between them
      if (kind == 18 && (n + 1 >= endIdx || isTarget[n+1])) begin
        kind = 0;
      end
      case (kind)
        0, 1, 2, 3, 4: begin
          prog[n] = rType(((f3 == 3'd0 || f3 == 3'd5) && randBelow(2) == 1) ? 7'b0100000 : 7'b0,
                          rs2, rs1, f3, rd);
        end
        5, 6, 7, 8: begin
          imm = 12'($random(seed));
          // shifts keep a legal upper field
          imm[11:5] = (f3 == 3'd1) ? 7'b0 : (f3 == 3'd5) ? {1'b0, imm[10], 5'b0} : imm[11:5];
          prog[n] = iType(imm, rs1, f3, rd, opImm);
        end
        9:  prog[n] = uType(20'($random(seed)), rd, opLui);
        10: prog[n] = uType(20'($random(seed)), rd, opAuipc);
        11, 12: begin
          // lb lh lw lbu lhu
          f3 = 3'(randBelow(5));
          f3 = (f3 > 3'd2) ? f3 + 3'd1 : f3;
          off = randBelow(memWindow) & ~((1 << f3[1:0]) - 1);
          prog[n] = iType(12'(off), 5'd0, f3, rd, opLoad);
        end
        13, 14: begin
          f3  = 3'(randBelow(3));
          off = randBelow(memWindow) & ~((1 << f3[1:0]) - 1);
          prog[n] = sType(12'(off), rs2, 5'd0, f3);
        end
        15, 16: begin
          // beq bne blt bge bltu bgeu
          f3 = 3'(randBelow(6));
          f3 = (f3 > 3'd1) ? f3 + 3'd2 : f3;
          tgt = pickTarget(n);
          prog[n] = bType(13'((tgt - n) * 4), rs2, rs1, f3);
        end
        17: begin
          tgt = pickTarget(n);
          prog[n] = jType(21'((tgt - n) * 4), rd);
        end
        18: begin
          // base plus offset lands on the target and the odd bit tests the clear
          rx  = regIdT'(1 + randBelow(7));
          tgt = pickTarget(n + 1);
          off = randBelow(3) * 4;
          prog[n]   = iType(12'(tgt * 4 - off), 5'd0, 3'd0, rx, opImm);
          prog[n+1] = iType(12'(off + randBelow(2)), rx, 3'd0, rd, opJalr);
          n++;
        end
        default: begin
          // unimplemented custom-0 opcode or ecall
          prog[n] = (randBelow(2) == 1) ? {25'($random(seed)), 7'b0001011} : 32'h00000073;
        end
      endcase
      n++;
    end
    prog[endIdx] = ebreakInst;
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic checkRegId(input string name, input regIdT got, input regIdT exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  // outputs sampled on the falling edge away from the updates
  task automatic waitReset(output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < resetTimeout && !ok; cycles++) begin
      @(negedge clk);
      ok = rstN;
    end
    if (!ok) begin
      $display("reset was not released within %0d cycles", resetTimeout);
      otherErrors++;
    end
  endtask

  task automatic waitRetire(output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < retireTimeout && !ok; cycles++) begin
      @(negedge clk);
      ok = (retireValid === 1'b1);
    end
    if (!ok) begin
      $display("no instruction retired within %0d cycles, model pc %h", retireTimeout, mPc);
      otherErrors++;
    end
  endtask

  // halted rises after ebreak and then the retire port stays quiet
  task automatic checkHaltWindow();
    int   cycles;
    wordT heldPc;
    @(negedge clk);
    checkFlag("halted", halted, 1'b1);
    // fetch address frozen from here on
    heldPc = instAddr;
    for (cycles = 0; cycles < haltWindow; cycles++) begin
      @(negedge clk);
      checkWord("instAddr", instAddr, heldPc);
      if (retireValid !== 1'b0) begin
        $display("instruction at pc %h retired after EBREAK", retirePc);
        otherErrors++;
      end
    end
  endtask

  initial begin
    bit    ok;
    wordT  ePc;
    logic  eWrite;
    regIdT eRd;
    wordT  eData;
    logic  eIllegal;
    logic  eHalt;
    buildProgram();
    resetModel(startPc);
    eHalt = 1'b0;
    waitReset(ok);
    if (ok) begin
      checkWord("instAddr", instAddr, startPc);
      checkFlag("retireValid", retireValid, 1'b0);
      checkFlag("halted", halted, 1'b0);
    end
    while (ok && !eHalt && retired < maxRetires) begin
      waitRetire(ok);
      if (ok) begin
        stepModel(prog[mPc[11:2]], ePc, eWrite, eRd, eData, eIllegal, eHalt);
        // a wrong-path retire shows up as a pc mismatch
        checkWord("retirePc", retirePc, ePc);
        checkFlag("retireWrite", retireWrite, eWrite);
        checkFlag("retireIllegal", retireIllegal, eIllegal);
        checkFlag("halted", halted, 1'b0);
        if (eWrite) begin
          checkRegId("retireRd", retireRd, eRd);
          checkWord("retireData", retireData, eData);
        end
        retired++;
      end
    end
    if (ok && !eHalt) begin
      $display("EBREAK did not retire within %0d instructions", maxRetires);
      otherErrors++;
    end
    if (ok && eHalt) begin
      checkHaltWindow();
    end
    $display("retired %0d, mismatches %0d, other errors %0d", retired, mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
